// ==== bench/tb_fetch.sv ====
`timescale 1ns/100ps

module tb_fetch;
    import fetch_pkg::*;

    localparam u32_t START_PC = RESET_PC_DEF;
    localparam int N_SEQ = 40;
    localparam int N_BP = 40;
    localparam int N_REDIR = 12;
    localparam int N_BTB = 13;
    localparam int N_UNC = 11;
    localparam int N_EXC = 5;
    localparam int TOTAL_OUT = N_SEQ + N_BP + N_REDIR * 4 + N_BTB + 2 * N_UNC + 2 * N_EXC;
    localparam int MAX_CYCLES = 40 * TOTAL_OUT;

    logic clk;
    logic rst_n;
    logic excp_redir_valid_i;
    u32_t excp_redir_pc_i;
    logic br_redir_valid_i;
    u32_t br_redir_pc_i;
    logic btb_upd_valid_i;
    u32_t btb_upd_pc_i;
    u32_t btb_upd_target_i;
    logic csr_da_i;
    u32_t csr_dmw0_i;
    logic out_valid_o;
    logic out_ready_i;
    u32_t out_pc_o;
    u32_t out_inst_o;
    excp_code_t out_excp_o;
    u32_t out_pred_npc_o;
    logic arvalid_o;
    logic arready_i;
    phy_t araddr_o;
    logic rvalid_i;
    logic rready_o;
    u32_t rdata_i;
    logic [1:0] rresp_i;

    integer seed;
    int err_count;
    int accept_count;
    int ar_reads;
    int cycles;
    int tests;
    int e0;
    int r0;
    int kind;
    logic bp_en;
    u32_t exp_pc;
    u32_t rpc;
    logic held;
    u32_t held_pc;
    u32_t held_inst;

    // reference btb, full pc kept per entry
    logic m_valid [16];
    u32_t m_pc [16];
    u32_t m_tgt [16];

    fetch_top UUT (.*);

    tb_mem_model u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .arvalid_i (arvalid_o),
        .arready_o (arready_i),
        .araddr_i  (araddr_o),
        .rvalid_o  (rvalid_i),
        .rready_i  (rready_o),
        .rdata_o   (rdata_i),
        .rresp_o   (rresp_i)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    function automatic u32_t translate_pa(input u32_t va);
        if (csr_da_i) begin
            return va;
        end
        return {csr_dmw0_i[27:25], va[28:0]};
    endfunction

    function automatic excp_code_t fetch_excp(input u32_t va);
        if (va[1:0] != 2'b00) begin
            return EXC_ADEF;
        end else if (!csr_da_i && va[31:29] != csr_dmw0_i[31:29]) begin
            return EXC_TLBR;
        end
        return EXC_NONE;
    endfunction

    function automatic u32_t predict_next(input u32_t pc);
        if (m_valid[pc[5:2]] && m_pc[pc[5:2]] == pc) begin
            return m_tgt[pc[5:2]];
        end
        return pc + 32'd4;
    endfunction

    // scoreboard, sampled mid-cycle where everything is settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (arvalid_o && arready_i) begin
                ar_reads++;
            end
            if (btb_upd_valid_i) begin
                m_valid[btb_upd_pc_i[5:2]] = 1'b1;
                m_pc[btb_upd_pc_i[5:2]] = btb_upd_pc_i;
                m_tgt[btb_upd_pc_i[5:2]] = btb_upd_target_i;
            end
            if (excp_redir_valid_i || br_redir_valid_i) begin
                check_val("out_valid_o", {31'b0, out_valid_o}, 32'd0);
                exp_pc = excp_redir_valid_i ? excp_redir_pc_i : br_redir_pc_i;
                held = 1'b0;
            end else begin
                if (held) begin
                    check_val("out_valid_o", {31'b0, out_valid_o}, 32'd1);
                    check_val("out_pc_o", out_pc_o, held_pc);
                    check_val("out_inst_o", out_inst_o, held_inst);
                end
                if (out_valid_o && out_ready_i) begin
                    check_val("out_pc_o", out_pc_o, exp_pc);
                    check_val("out_excp_o", {30'b0, out_excp_o}, {30'b0, fetch_excp(exp_pc)});
                    if (fetch_excp(exp_pc) == EXC_NONE) begin
                        check_val("out_inst_o", out_inst_o,
                                  translate_pa(exp_pc) ^ 32'ha5a5_0000);
                    end
                    check_val("out_pred_npc_o", out_pred_npc_o, predict_next(exp_pc));
                    exp_pc = predict_next(exp_pc);
                    accept_count++;
                end
                held = out_valid_o && !out_ready_i;
                held_pc = out_pc_o;
                held_inst = out_inst_o;
            end
        end
    end

    // random back-pressure when enabled
    always @(posedge clk) begin
        out_ready_i <= bp_en ? (($random(seed) & 3) != 0) : 1'b1;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d outputs accepted", cycles, accept_count);
            $display("sim failed");
            $finish;
        end
    end

    task automatic wait_outputs(input int n);
        int target;
        target = accept_count + n;
        wait (accept_count >= target);
    endtask

    task automatic redirect(input logic ev, input u32_t epc, input logic bv, input u32_t bpc);
        @(posedge clk);
        excp_redir_valid_i <= ev;
        excp_redir_pc_i <= epc;
        br_redir_valid_i <= bv;
        br_redir_pc_i <= bpc;
        @(posedge clk);
        excp_redir_valid_i <= 1'b0;
        br_redir_valid_i <= 1'b0;
    endtask

    // csr switch lands together with a flush to a new pc
    task automatic switch_mode(input logic da, input u32_t dmw, input u32_t pc);
        @(posedge clk);
        csr_da_i <= da;
        csr_dmw0_i <= dmw;
        br_redir_valid_i <= 1'b1;
        br_redir_pc_i <= pc;
        @(posedge clk);
        br_redir_valid_i <= 1'b0;
    endtask

    task automatic train_btb(input u32_t pc, input u32_t tgt);
        @(posedge clk);
        btb_upd_valid_i <= 1'b1;
        btb_upd_pc_i <= pc;
        btb_upd_target_i <= tgt;
        @(posedge clk);
        btb_upd_valid_i <= 1'b0;
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        $display("%s: %s, %0d outputs so far", name,
                 (err_count == errs_before) ? "ok" : "mismatches", accept_count);
    endtask

    task automatic count_reads(input int n, input int expected);
        wait_outputs(1);
        r0 = ar_reads;
        wait_outputs(n);
        check_val("ar_reads", ar_reads - r0, expected);
    endtask

    initial begin
        seed = 32'h3ae0_5c8b;
        err_count = 0;
        accept_count = 0;
        ar_reads = 0;
        cycles = 0;
        tests = 0;
        bp_en = 1'b0;
        held = 1'b0;
        exp_pc = START_PC;
        for (int i = 0; i < 16; i++) begin
            m_valid[i] = 1'b0;
        end
        rst_n = 1'b0;
        excp_redir_valid_i = 1'b0;
        excp_redir_pc_i = '0;
        br_redir_valid_i = 1'b0;
        br_redir_pc_i = '0;
        btb_upd_valid_i = 1'b0;
        btb_upd_pc_i = '0;
        btb_upd_target_i = '0;
        csr_da_i = 1'b0;
        // segment 0 mapped onto physical segment 1, cached
        csr_dmw0_i = 32'h0200_0010;
        out_ready_i = 1'b1;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        e0 = err_count;
        wait_outputs(N_SEQ);
        report_test("sequential fetch", e0);

        e0 = err_count;
        bp_en = 1'b1;
        wait_outputs(N_BP);
        bp_en = 1'b0;
        report_test("back-pressure", e0);

        e0 = err_count;
        repeat (N_REDIR) begin
            wait_outputs(1);
            kind = $random(seed) & 3;
            rpc = 32'h1c00_0000 | ($random(seed) & 32'h0000_0ffc);
            redirect(kind != 1, rpc, kind != 0, rpc ^ 32'h0000_0440);
            wait_outputs(3);
        end
        report_test("redirect priority", e0);

        e0 = err_count;
        wait_outputs(1);
        train_btb(32'h1c00_0800, 32'h1c00_0400);
        redirect(1'b0, '0, 1'b1, 32'h1c00_0800);
        wait_outputs(6);
        // same index, other tag
        train_btb(32'h1c00_0840, 32'h1c00_0600);
        redirect(1'b0, '0, 1'b1, 32'h1c00_0800);
        wait_outputs(6);
        report_test("btb prediction", e0);

        e0 = err_count;
        switch_mode(1'b1, 32'h0000_0010, 32'h1c00_0000);
        count_reads(N_UNC - 1, N_UNC - 1);
        switch_mode(1'b0, 32'h0200_0000, 32'h1c00_0200);
        count_reads(N_UNC - 1, N_UNC - 1);
        report_test("uncached and direct", e0);

        e0 = err_count;
        switch_mode(1'b0, 32'h0000_0010, 32'h1c00_0102);
        count_reads(N_EXC - 1, 0);
        redirect(1'b1, 32'h8000_0000, 1'b0, '0);
        count_reads(N_EXC - 1, 0);
        report_test("fetch exceptions", e0);

        $display("tests %0d, outputs %0d, errors %0d", tests, accept_count, err_count);
        if (err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== bench/tb_mem_model.sv ====
`timescale 1ns/100ps

// axi4-lite read slave, every word is its address xor a fixed pattern
module tb_mem_model #(
    parameter int SEED = 32'h3ae0_5c8b
) (
    input logic clk,
    input logic rst_n,
    input logic arvalid_i,
    output logic arready_o,
    input logic [31:0] araddr_i,
    output logic rvalid_o,
    input logic rready_i,
    output logic [31:0] rdata_o,
    output logic [1:0] rresp_o
);

    integer seed;
    int ar_dly;
    int r_dly;
    logic busy;
    logic [31:0] addr_q;

    initial begin
        seed = SEED;
    end

    assign rresp_o = 2'b00;

    always @(posedge clk) begin
        if (!rst_n) begin
            arready_o <= 1'b0;
            rvalid_o <= 1'b0;
            rdata_o <= '0;
            busy <= 1'b0;
            ar_dly <= 0;
            r_dly <= 0;
            addr_q <= '0;
        end else begin
            if (arvalid_i && arready_o) begin
                arready_o <= 1'b0;
                addr_q <= araddr_i;
                busy <= 1'b1;
                r_dly <= $random(seed) & 3;
            end else if (arvalid_i && !busy && !arready_o) begin
                // zero to three idle cycles before accepting the address
                if (ar_dly == 0) begin
                    arready_o <= 1'b1;
                end else begin
                    ar_dly <= ar_dly - 1;
                end
            end
            if (busy && !rvalid_o) begin
                if (r_dly == 0) begin
                    rvalid_o <= 1'b1;
                    rdata_o <= addr_q ^ 32'ha5a5_0000;
                end else begin
                    r_dly <= r_dly - 1;
                end
            end
            if (rvalid_o && rready_i) begin
                rvalid_o <= 1'b0;
                busy <= 1'b0;
                ar_dly <= $random(seed) & 3;
            end
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run with verilator, pass is decided from the log
cd "$(dirname "$0")" &&
verilator --binary --timing -f tb.f --top-module tb_fetch -o tb_fetch_sim > build.log 2>&1 &&
./obj_dir/tb_fetch_sim > sim.log 2>&1 ||
{ echo "build or run error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -qx "sim passed" sim.log || exit 1

// ==== tb.f ====
verilog/fetch_pkg.sv
verilog/fetch_ifs.sv
verilog/btb.sv
verilog/addr_trans.sv
verilog/fetch1.sv
verilog/icache.sv
verilog/fetch_top.sv
bench/tb_mem_model.sv
bench/tb_fetch.sv

// ==== verilog/addr_trans.sv ====
`timescale 1ns/100ps

module addr_trans (
    input fetch_pkg::u32_t va_i,

    // translation controls from csr
    input logic csr_da_i,
    input fetch_pkg::u32_t csr_dmw0_i,

    output fetch_pkg::phy_t pa_o,
    output logic cached_o,
    output fetch_pkg::excp_code_t excp_o
);
    import fetch_pkg::*;

    logic misaligned;
    logic win_hit;

    assign misaligned = |va_i[1:0];

    // virtual segment of the window sits in the top three bits
    assign win_hit = (va_i[31:29] == csr_dmw0_i[31:29]);

    always_comb begin
        pa_o = va_i;
        cached_o = 1'b0;
        excp_o = EXC_NONE;
        if (misaligned) begin
            excp_o = EXC_ADEF;
        end else if (csr_da_i) begin
            // direct address mode, identity and uncached
            pa_o = va_i;
        end else if (win_hit) begin
            pa_o = {csr_dmw0_i[27:25], va_i[28:0]};
            cached_o = csr_dmw0_i[4];
        end else begin
            // no tlb behind the window
            excp_o = EXC_TLBR;
        end
    end

endmodule

// ==== verilog/btb.sv ====
`timescale 1ns/100ps

module btb #(
    parameter int BTB_IDX_BITS = fetch_pkg::BTB_IDX_BITS_DEF
) (
    input logic clk,
    input logic rst_n,

    btb_lookup_if.btb lk,

    // training from branch resolution
    input logic upd_valid_i,
    input fetch_pkg::u32_t upd_pc_i,
    input fetch_pkg::u32_t upd_target_i
);
    import fetch_pkg::*;

    localparam int ENTRIES = 1 << BTB_IDX_BITS;

    typedef logic [BTB_IDX_BITS-1:0] btb_idx_t;

    logic [ENTRIES-1:0] valid_q;
    btb_tag_t tag_q [ENTRIES];
    u32_t target_q [ENTRIES];

    btb_idx_t lk_idx;
    btb_idx_t upd_idx;
    btb_tag_t lk_tag;
    btb_tag_t upd_tag;

    logic pred_valid_q;
    u32_t pred_npc_q;

    // word aligned pcs, so the index starts at bit 2
    assign lk_idx = lk.pc[BTB_IDX_BITS+1:2];
    assign lk_tag = btb_tag_t'(lk.pc >> (BTB_IDX_BITS + 2));
    assign upd_idx = upd_pc_i[BTB_IDX_BITS+1:2];
    assign upd_tag = btb_tag_t'(upd_pc_i >> (BTB_IDX_BITS + 2));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            pred_valid_q <= 1'b0;
        end else begin
            if (upd_valid_i) begin
                valid_q[upd_idx] <= 1'b1;
            end
            // the result belongs to the pc loaded on this edge
            if (!lk.stall) begin
                pred_valid_q <= valid_q[lk_idx] & (tag_q[lk_idx] == lk_tag);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (upd_valid_i) begin
            tag_q[upd_idx] <= upd_tag;
            target_q[upd_idx] <= upd_target_i;
        end
        if (!lk.stall) begin
            pred_npc_q <= target_q[lk_idx];
        end
    end

    assign lk.pred_valid = pred_valid_q;
    assign lk.pred_npc = pred_npc_q;

endmodule

// ==== verilog/fetch1.sv ====
`timescale 1ns/100ps

module fetch1 #(
    parameter fetch_pkg::u32_t RESET_PC = fetch_pkg::RESET_PC_DEF
) (
    input logic clk,
    input logic rst_n,

    // redirects, exception first
    input logic excp_redir_valid_i,
    input fetch_pkg::u32_t excp_redir_pc_i,
    input logic br_redir_valid_i,
    input fetch_pkg::u32_t br_redir_pc_i,

    input logic csr_da_i,
    input fetch_pkg::u32_t csr_dmw0_i,

    btb_lookup_if.fetch btb,
    icache_req_if.fetch ic,

    // to decode
    input logic out_ready_i,
    output logic out_valid_o,
    output fetch_pkg::u32_t out_pc_o,
    output fetch_pkg::u32_t out_inst_o,
    output fetch_pkg::excp_code_t out_excp_o,
    output fetch_pkg::u32_t out_pred_npc_o
);
    import fetch_pkg::*;

    u32_t pc_r;
    u32_t npc;
    phy_t pa;
    logic cached;
    excp_code_t excp;

    logic redirect;
    logic fetch_go;
    logic cache_wait;
    logic stall;
    logic pc_en;

    addr_trans u_addr_trans (
        .va_i       (pc_r),
        .csr_da_i   (csr_da_i),
        .csr_dmw0_i (csr_dmw0_i),
        .pa_o       (pa),
        .cached_o   (cached),
        .excp_o     (excp)
    );

    assign redirect = excp_redir_valid_i | br_redir_valid_i;

    // a faulting pc never touches the cache
    assign fetch_go = (excp == EXC_NONE);
    assign cache_wait = fetch_go & ~ic.ready;
    assign stall = cache_wait | ~out_ready_i;

    // a redirect flushes and loads regardless of stall
    assign pc_en = ~stall | redirect;

    always_comb begin
        if (excp_redir_valid_i) begin
            npc = excp_redir_pc_i;
        end else if (br_redir_valid_i) begin
            npc = br_redir_pc_i;
        end else if (btb.pred_valid) begin
            // prediction was looked up for the pc now in pc_r
            npc = btb.pred_npc;
        end else begin
            npc = pc_r + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_r <= RESET_PC;
        end else if (pc_en) begin
            pc_r <= npc;
        end
    end

    // btb indexes the pc that pc_r takes next
    assign btb.pc = npc;
    assign btb.stall = ~pc_en;

    // no new miss is started in a flush cycle
    assign ic.req = fetch_go & ~redirect;
    assign ic.idx = pc_r[IC_IDX_W-1:0];
    assign ic.pa = pa;
    assign ic.is_cached = cached;

    assign out_valid_o = ~redirect & (~fetch_go | ic.ready);
    assign out_pc_o = pc_r;
    assign out_inst_o = fetch_go ? ic.inst : '0;
    assign out_excp_o = excp;
    assign out_pred_npc_o = npc;

endmodule

// ==== verilog/fetch_ifs.sv ====
`timescale 1ns/100ps

// next pc lookup into the btb, result comes back one cycle later
interface btb_lookup_if;
    import fetch_pkg::*;

    logic stall;
    u32_t pc;
    logic pred_valid;
    u32_t pred_npc;

    modport fetch (output stall, output pc, input pred_valid, input pred_npc);
    modport btb (input stall, input pc, output pred_valid, output pred_npc);
endinterface

// fetch request into the instruction cache
interface icache_req_if;
    import fetch_pkg::*;

    logic req;
    ic_idx_t idx;
    phy_t pa;
    logic is_cached;
    logic ready;
    u32_t inst;

    modport fetch (
        output req, output idx, output pa, output is_cached,
        input ready, input inst
    );
    modport cache (
        input req, input idx, input pa, input is_cached,
        output ready, output inst
    );
endinterface

// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

    // basic data path widths
    localparam int XLEN = 32;
    localparam int BTB_TAG_W = 26;

    // the cache index travels as the page offset of the fetch address
    localparam int IC_IDX_W = 12;

    // words per instruction cache line
    localparam int IC_LINE_WORDS = 4;

    // virtual address or instruction word
    typedef logic [XLEN-1:0] u32_t;

    // physical address
    typedef logic [XLEN-1:0] phy_t;

    // pc bits above the btb index
    typedef logic [BTB_TAG_W-1:0] btb_tag_t;

    // untranslated low bits of the pc, used to index the cache
    typedef logic [IC_IDX_W-1:0] ic_idx_t;

    // fetch exception reported beside the instruction
    typedef enum logic [1:0] {
        EXC_NONE = 2'd0,
        EXC_ADEF = 2'd1,
        EXC_TLBR = 2'd2
    } excp_code_t;

    // instruction cache refill fsm
    typedef enum logic [1:0] {
        IC_IDLE     = 2'd0,
        IC_REFILL   = 2'd1,
        IC_UNCACHED = 2'd2,
        IC_DONE     = 2'd3
    } icache_state_t;

    // defaults picked up by the top level
    localparam u32_t RESET_PC_DEF = 32'h1c00_0000;
    localparam int BTB_IDX_BITS_DEF = 4;
    localparam int IC_LINES_DEF = 16;

endpackage

// ==== verilog/fetch_top.sv ====
`timescale 1ns/100ps

module fetch_top #(
    parameter fetch_pkg::u32_t RESET_PC = fetch_pkg::RESET_PC_DEF,
    parameter int BTB_IDX_BITS = fetch_pkg::BTB_IDX_BITS_DEF,
    parameter int IC_LINES = fetch_pkg::IC_LINES_DEF
) (
    input logic clk,
    input logic rst_n,

    // redirects
    input logic excp_redir_valid_i,
    input fetch_pkg::u32_t excp_redir_pc_i,
    input logic br_redir_valid_i,
    input fetch_pkg::u32_t br_redir_pc_i,

    // btb training
    input logic btb_upd_valid_i,
    input fetch_pkg::u32_t btb_upd_pc_i,
    input fetch_pkg::u32_t btb_upd_target_i,

    // csr values
    input logic csr_da_i,
    input fetch_pkg::u32_t csr_dmw0_i,

    // decode side
    output logic out_valid_o,
    input logic out_ready_i,
    output fetch_pkg::u32_t out_pc_o,
    output fetch_pkg::u32_t out_inst_o,
    output fetch_pkg::excp_code_t out_excp_o,
    output fetch_pkg::u32_t out_pred_npc_o,

    // axi4-lite read master
    output logic arvalid_o,
    input logic arready_i,
    output fetch_pkg::phy_t araddr_o,
    input logic rvalid_i,
    output logic rready_o,
    input fetch_pkg::u32_t rdata_i,
    input logic [1:0] rresp_i
);

    btb_lookup_if u_btb_if ();
    icache_req_if u_ic_if ();

    fetch1 #(
        .RESET_PC (RESET_PC)
    ) u_fetch1 (
        .clk                (clk),
        .rst_n              (rst_n),
        .excp_redir_valid_i (excp_redir_valid_i),
        .excp_redir_pc_i    (excp_redir_pc_i),
        .br_redir_valid_i   (br_redir_valid_i),
        .br_redir_pc_i      (br_redir_pc_i),
        .csr_da_i           (csr_da_i),
        .csr_dmw0_i         (csr_dmw0_i),
        .btb                (u_btb_if.fetch),
        .ic                 (u_ic_if.fetch),
        .out_ready_i        (out_ready_i),
        .out_valid_o        (out_valid_o),
        .out_pc_o           (out_pc_o),
        .out_inst_o         (out_inst_o),
        .out_excp_o         (out_excp_o),
        .out_pred_npc_o     (out_pred_npc_o)
    );

    btb #(
        .BTB_IDX_BITS (BTB_IDX_BITS)
    ) u_btb (
        .clk          (clk),
        .rst_n        (rst_n),
        .lk           (u_btb_if.btb),
        .upd_valid_i  (btb_upd_valid_i),
        .upd_pc_i     (btb_upd_pc_i),
        .upd_target_i (btb_upd_target_i)
    );

    icache #(
        .IC_LINES (IC_LINES)
    ) u_icache (
        .clk       (clk),
        .rst_n     (rst_n),
        .ic        (u_ic_if.cache),
        .arvalid_o (arvalid_o),
        .arready_i (arready_i),
        .araddr_o  (araddr_o),
        .rvalid_i  (rvalid_i),
        .rready_o  (rready_o),
        .rdata_i   (rdata_i),
        .rresp_i   (rresp_i)
    );

endmodule

// ==== verilog/icache.sv ====
`timescale 1ns/100ps

module icache #(
    parameter int IC_LINES = fetch_pkg::IC_LINES_DEF
) (
    input logic clk,
    input logic rst_n,

    icache_req_if.cache ic,

    // axi4-lite read address channel
    output logic arvalid_o,
    input logic arready_i,
    output fetch_pkg::phy_t araddr_o,

    // axi4-lite read data channel, response code is not checked
    input logic rvalid_i,
    output logic rready_o,
    input fetch_pkg::u32_t rdata_i,
    input logic [1:0] rresp_i
);
    import fetch_pkg::*;

    localparam int LINE_W = $clog2(IC_LINES);
    localparam int WORD_W = $clog2(IC_LINE_WORDS);
    localparam int OFS_W = WORD_W + 2;
    localparam int TAG_W = XLEN - LINE_W - OFS_W;

    typedef logic [TAG_W-1:0] ic_tag_t;
    typedef logic [LINE_W-1:0] ic_line_t;
    typedef logic [WORD_W-1:0] ic_word_t;

    logic [IC_LINES-1:0] valid_q;
    ic_tag_t tag_q [IC_LINES];
    u32_t data_q [IC_LINES*IC_LINE_WORDS];

    icache_state_t state_q;
    icache_state_t state_d;
    phy_t miss_pa_q;
    u32_t word_q;
    ic_word_t beat_q;
    logic addr_sent_q;

    ic_line_t hit_line;
    ic_word_t hit_word;
    ic_line_t miss_line;
    logic hit;
    logic busy;
    logic r_fire;
    logic last_beat;
    logic done_match;

    // index from the untranslated offset, tag from the physical address
    assign hit_line = ic.idx[OFS_W +: LINE_W];
    assign hit_word = ic.idx[2 +: WORD_W];
    assign hit = ic.req & ic.is_cached & valid_q[hit_line]
               & (tag_q[hit_line] == ic.pa[XLEN-1 -: TAG_W]);

    assign miss_line = miss_pa_q[OFS_W +: LINE_W];
    assign busy = (state_q == IC_REFILL) | (state_q == IC_UNCACHED);
    assign r_fire = rvalid_i & rready_o;
    assign last_beat = (state_q == IC_UNCACHED) | (&beat_q);

    // the fetched word only answers the request it was read for
    assign done_match = ic.req & (ic.pa == miss_pa_q);

    // one address in flight, then wait for its data
    assign arvalid_o = busy & ~addr_sent_q;
    assign rready_o = busy & addr_sent_q;
    assign araddr_o = (state_q == IC_REFILL) ? {miss_pa_q[XLEN-1:OFS_W], beat_q, 2'b00}
                                             : miss_pa_q;

    always_comb begin
        ic.ready = 1'b0;
        ic.inst = data_q[{hit_line, hit_word}];
        if (state_q == IC_IDLE) begin
            ic.ready = hit;
        end else if (state_q == IC_DONE) begin
            ic.ready = done_match;
            ic.inst = word_q;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IC_IDLE: begin
                if (ic.req && !hit) begin
                    state_d = ic.is_cached ? IC_REFILL : IC_UNCACHED;
                end
            end
            IC_REFILL, IC_UNCACHED: begin
                if (r_fire && last_beat) begin
                    state_d = IC_DONE;
                end
            end
            // hold the word until fetch moves on to another address
            IC_DONE: begin
                if (!done_match) begin
                    state_d = IC_IDLE;
                end
            end
            default: state_d = IC_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IC_IDLE;
            valid_q <= '0;
            beat_q <= '0;
            addr_sent_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (arvalid_o && arready_i) begin
                addr_sent_q <= 1'b1;
            end
            if (state_q == IC_IDLE) begin
                beat_q <= '0;
            end
            if (r_fire) begin
                addr_sent_q <= 1'b0;
                beat_q <= beat_q + 1'b1;
                if (state_q == IC_REFILL && last_beat) begin
                    valid_q[miss_line] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IC_IDLE && ic.req && !hit) begin
            miss_pa_q <= ic.pa;
        end
        if (r_fire) begin
            if (state_q == IC_REFILL) begin
                data_q[{miss_line, beat_q}] <= rdata_i;
            end
            if ((state_q == IC_UNCACHED) || (beat_q == miss_pa_q[2 +: WORD_W])) begin
                word_q <= rdata_i;
            end
            if (state_q == IC_REFILL && last_beat) begin
                tag_q[miss_line] <= miss_pa_q[XLEN-1 -: TAG_W];
            end
        end
    end

endmodule
